//--- bridge_pkg.sv
package bridge_pkg;

    // Widths with a meaning of their own
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  resp_t;   // AXI response code
    typedef logic [7:0]  status_t;

    // Command bytes accepted by the parser
    localparam byte_t CMD_WRITE = 8'h01;
    localparam byte_t CMD_READ  = 8'h81;

    // Answer for any other command byte
    localparam status_t STATUS_BAD_CMD = 8'h07;

    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    typedef enum logic [2:0] {P_CMD, P_ADDR, P_DATA} parse_state_t;

    typedef enum logic [2:0] {
        AX_IDLE,
        AX_WRITE,    // AW and W outstanding
        AX_BRESP,
        AX_READ,     // AR outstanding
        AX_RRESP,
        AX_DONE      // Result held for the builder
    } axi_state_t;

    typedef enum logic [2:0] {B_IDLE, B_STATUS, B_DATA} build_state_t;

    typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int clks_per_bit = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              uart_rx,
    output bridge_pkg::byte_t rx_byte,
    output logic              rx_byte_valid
);
    import bridge_pkg::*;

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] half_bit = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [cnt_w-1:0] full_bit = cnt_w'(clks_per_bit - 1);

    rx_state_t        state;
    logic [1:0]       sync;       // Two-flop synchronizer
    logic             rx_s;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    byte_t            shift;

    assign rx_s    = sync[1];
    assign rx_byte = shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync          <= 2'b11;   // Line idles high
            state         <= RX_IDLE;
            baud_cnt      <= '0;
            bit_cnt       <= '0;
            rx_byte_valid <= 1'b0;
        end else begin
            sync          <= {sync[0], uart_rx};
            rx_byte_valid <= 1'b0;
            baud_cnt      <= baud_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_s) state <= RX_START;
                end
                RX_START: if (baud_cnt == half_bit) begin
                    // A high line at mid start bit was a glitch
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    state    <= rx_s ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (baud_cnt == full_bit) begin
                    baud_cnt <= '0;
                    bit_cnt  <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (baud_cnt == full_bit) begin
                    rx_byte_valid <= rx_s;    // Low stop bit drops the byte
                    state         <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && baud_cnt == full_bit) shift <= {rx_s, shift[7:1]};
    end

endmodule

//--- frame_parser.sv
`timescale 1ns/1ps

module frame_parser (
    input  logic              clk,
    input  logic              rst,
    input  bridge_pkg::byte_t rx_byte,
    input  logic              rx_byte_valid,
    output logic              req_valid,
    output logic              req_is_read,
    output bridge_pkg::addr_t req_addr,
    output bridge_pkg::word_t req_wdata,
    input  logic              req_ready,
    output logic              bad_cmd_valid,
    input  logic              bad_cmd_ready
);
    import bridge_pkg::*;

    parse_state_t state;
    logic [1:0]   byte_cnt;
    logic         frame_read;     // Command of the frame being received
    addr_t        addr_sr;
    word_t        data_sr;
    logic         frame_done;
    logic         load_req;

    // Last byte of a frame arrives now
    assign frame_done = rx_byte_valid && byte_cnt == 2'd3
                        && ((state == P_ADDR && frame_read) || state == P_DATA);
    // A frame finishing while the request is still held is lost
    assign load_req = frame_done && (!req_valid || req_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= P_CMD;
            byte_cnt      <= '0;
            req_valid     <= 1'b0;
            bad_cmd_valid <= 1'b0;
        end else begin
            if (req_ready) req_valid <= 1'b0;
            if (bad_cmd_ready) bad_cmd_valid <= 1'b0;
            if (load_req) req_valid <= 1'b1;
            if (rx_byte_valid) begin
                case (state)
                    P_CMD: begin
                        byte_cnt <= '0;
                        if (rx_byte == CMD_WRITE || rx_byte == CMD_READ) state <= P_ADDR;
                        else bad_cmd_valid <= 1'b1;
                    end
                    P_ADDR: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) state <= frame_read ? P_CMD : P_DATA;
                    end
                    P_DATA: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) state <= P_CMD;
                    end
                    default: state <= P_CMD;
                endcase
            end
        end
    end

    // Shift registers fill MSB first
    always_ff @(posedge clk) begin
        if (rx_byte_valid && state == P_CMD) frame_read <= (rx_byte == CMD_READ);
        if (rx_byte_valid && state == P_ADDR) addr_sr <= {addr_sr[23:0], rx_byte};
        if (rx_byte_valid && state == P_DATA) data_sr <= {data_sr[23:0], rx_byte};
        if (load_req) begin
            req_is_read <= frame_read;
            req_addr    <= frame_read ? {addr_sr[23:0], rx_byte} : addr_sr;
            req_wdata   <= {data_sr[23:0], rx_byte};  // Don't care on reads
        end
    end

endmodule

//--- axil_master.sv
`timescale 1ns/1ps

module axil_master (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  logic              req_is_read,
    input  bridge_pkg::addr_t req_addr,
    input  bridge_pkg::word_t req_wdata,
    output logic              req_ready,
    output bridge_pkg::addr_t awaddr,
    output logic              awvalid,
    input  logic              awready,
    output bridge_pkg::word_t wdata,
    output logic [3:0]        wstrb,
    output logic              wvalid,
    input  logic              wready,
    input  bridge_pkg::resp_t bresp,
    input  logic              bvalid,
    output logic              bready,
    output bridge_pkg::addr_t araddr,
    output logic              arvalid,
    input  logic              arready,
    input  bridge_pkg::word_t rdata,
    input  bridge_pkg::resp_t rresp,
    input  logic              rvalid,
    output logic              rready,
    output logic              res_valid,
    output logic              res_is_read,
    output bridge_pkg::resp_t res_resp,
    output bridge_pkg::word_t res_rdata,
    input  logic              res_ready
);
    import bridge_pkg::*;

    axi_state_t state;
    logic       aw_left;          // AW still pending after this cycle
    logic       w_left;

    assign req_ready = (state == AX_IDLE);
    assign arvalid   = (state == AX_READ);
    assign bready    = (state == AX_BRESP);
    assign rready    = (state == AX_RRESP);
    assign res_valid = (state == AX_DONE);
    assign wstrb     = 4'hf;                  // Full word writes only

    assign aw_left = awvalid && !awready;
    assign w_left  = wvalid && !wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= AX_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                AX_IDLE: if (req_valid) begin
                    awvalid <= !req_is_read;  // AW and W rise together
                    wvalid  <= !req_is_read;
                    state   <= req_is_read ? AX_READ : AX_WRITE;
                end
                AX_WRITE: begin
                    awvalid <= aw_left;
                    wvalid  <= w_left;
                    if (!aw_left && !w_left) state <= AX_BRESP;
                end
                AX_BRESP: if (bvalid) state <= AX_DONE;
                AX_READ:  if (arready) state <= AX_RRESP;
                AX_RRESP: if (rvalid) state <= AX_DONE;
                AX_DONE:  if (res_ready) state <= AX_IDLE;
                default:  state <= AX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == AX_IDLE && req_valid) begin
            awaddr      <= req_addr;
            araddr      <= req_addr;
            wdata       <= req_wdata;
            res_is_read <= req_is_read;
        end
        if (state == AX_BRESP && bvalid) res_resp <= bresp;
        if (state == AX_RRESP && rvalid) begin
            res_resp  <= rresp;
            res_rdata <= rdata;
        end
    end

endmodule

//--- response_builder.sv
`timescale 1ns/1ps

module response_builder (
    input  logic              clk,
    input  logic              rst,
    input  logic              res_valid,
    input  logic              res_is_read,
    input  bridge_pkg::resp_t res_resp,
    input  bridge_pkg::word_t res_rdata,
    output logic              res_ready,
    input  logic              bad_cmd_valid,
    output logic              bad_cmd_ready,
    output bridge_pkg::byte_t tx_byte,
    output logic              tx_valid,
    input  logic              tx_ready
);
    import bridge_pkg::*;

    build_state_t state;
    logic [1:0]   byte_cnt;
    status_t      status;
    word_t        data;           // Read data shifted out from the top
    logic         with_data;

    // Unknown command wins over a bus result
    assign bad_cmd_ready = (state == B_IDLE);
    assign res_ready     = (state == B_IDLE) && !bad_cmd_valid;
    assign tx_valid      = (state != B_IDLE);
    assign tx_byte       = (state == B_STATUS) ? status : data[31:24];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= B_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                B_IDLE: if (bad_cmd_valid || res_valid) state <= B_STATUS;
                B_STATUS: if (tx_ready) begin
                    byte_cnt <= '0;
                    state    <= with_data ? B_DATA : B_IDLE;
                end
                B_DATA: if (tx_ready) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd3) state <= B_IDLE;
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == B_IDLE && bad_cmd_valid) begin
            status    <= STATUS_BAD_CMD;
            with_data <= 1'b0;
        end else if (state == B_IDLE && res_valid) begin
            status    <= status_t'(res_resp);
            with_data <= res_is_read && res_resp == 2'b00;  // OKAY read only
            data      <= res_rdata;
        end else if (state == B_DATA && tx_ready) begin
            data <= data << 8;
        end
    end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int clks_per_bit = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  bridge_pkg::byte_t tx_byte,
    input  logic              tx_valid,
    output logic              tx_ready,
    output logic              uart_tx
);
    import bridge_pkg::*;

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] full_bit = cnt_w'(clks_per_bit - 1);

    tx_state_t        state;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    byte_t            shift;
    logic             bit_end;

    assign tx_ready = (state == TX_IDLE);
    assign bit_end  = (baud_cnt == full_bit);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            uart_tx  <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            baud_cnt <= (state == TX_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
            case (state)
                TX_IDLE: if (tx_valid) begin
                    uart_tx <= 1'b0;          // Start bit
                    state   <= TX_START;
                end
                TX_START: if (bit_end) begin
                    uart_tx <= shift[0];
                    bit_cnt <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    uart_tx <= (bit_cnt == 3'd7) ? 1'b1 : shift[0];
                    if (bit_cnt == 3'd7) state <= TX_STOP;
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_valid) shift <= tx_byte;
        else if ((state == TX_START || state == TX_DATA) && bit_end) shift <= shift >> 1;
    end

endmodule

//--- uart_axil_bridge.sv
`timescale 1ns/1ps

module uart_axil_bridge #(
    parameter int clks_per_bit = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              uart_rx,
    output logic              uart_tx,
    output bridge_pkg::addr_t awaddr,
    output logic              awvalid,
    input  logic              awready,
    output bridge_pkg::word_t wdata,
    output logic [3:0]        wstrb,
    output logic              wvalid,
    input  logic              wready,
    input  bridge_pkg::resp_t bresp,
    input  logic              bvalid,
    output logic              bready,
    output bridge_pkg::addr_t araddr,
    output logic              arvalid,
    input  logic              arready,
    input  bridge_pkg::word_t rdata,
    input  bridge_pkg::resp_t rresp,
    input  logic              rvalid,
    output logic              rready
);
    import bridge_pkg::*;

    byte_t rx_byte;
    logic  rx_byte_valid;

    // Parser to bus master
    logic  req_valid;
    logic  req_ready;
    logic  req_is_read;
    addr_t req_addr;
    word_t req_wdata;

    logic  bad_cmd_valid;
    logic  bad_cmd_ready;

    // Bus result to builder
    logic  res_valid;
    logic  res_ready;
    logic  res_is_read;
    resp_t res_resp;
    word_t res_rdata;

    byte_t tx_byte;
    logic  tx_valid;
    logic  tx_ready;

    uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
        .clk(clk), .rst(rst), .uart_rx(uart_rx),
        .rx_byte(rx_byte), .rx_byte_valid(rx_byte_valid)
    );

    frame_parser u_parser (
        .clk(clk), .rst(rst),
        .rx_byte(rx_byte), .rx_byte_valid(rx_byte_valid),
        .req_valid(req_valid), .req_is_read(req_is_read),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_ready(req_ready),
        .bad_cmd_valid(bad_cmd_valid), .bad_cmd_ready(bad_cmd_ready)
    );

    axil_master u_master (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_is_read(req_is_read),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_ready(req_ready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .res_valid(res_valid), .res_is_read(res_is_read),
        .res_resp(res_resp), .res_rdata(res_rdata), .res_ready(res_ready)
    );

    response_builder u_builder (
        .clk(clk), .rst(rst),
        .res_valid(res_valid), .res_is_read(res_is_read),
        .res_resp(res_resp), .res_rdata(res_rdata), .res_ready(res_ready),
        .bad_cmd_valid(bad_cmd_valid), .bad_cmd_ready(bad_cmd_ready),
        .tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
        .clk(clk), .rst(rst),
        .tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .uart_tx(uart_tx)
    );

endmodule

//--- uart_axil_bridge_properties.sv
`timescale 1ns/1ps

module uart_axil_bridge_properties (
    input logic              clk,
    input logic              rst,
    input bridge_pkg::addr_t awaddr,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready,
    input logic              bready,
    input bridge_pkg::addr_t araddr,
    input logic              arvalid,
    input logic              arready,
    input logic              res_is_read
);

    int fail_count = 0;

    // Valids hold until their ready
    aw_held: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    w_held: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            fail_count++;
        end

    ar_held: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            fail_count++;
        end

    aw_stable: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> $stable(awaddr))
        else begin
            $error("awaddr changed while awvalid waited");
            fail_count++;
        end

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> $stable(araddr))
        else begin
            $error("araddr changed while arvalid waited");
            fail_count++;
        end

    // Only after both write channels finished
    b_in_write: assert property (@(posedge clk) disable iff (rst)
        bready |-> !res_is_read && !awvalid && !wvalid && !arvalid)
        else begin
            $error("bready high outside a write");
            fail_count++;
        end

endmodule

//--- tb_uart_axil_bridge.sv
`timescale 1ns/1ps

module tb_uart_axil_bridge;
    import bridge_pkg::*;

    localparam int clks_per_bit = 8;
    localparam int num_frames   = 16;
    localparam int rec_len      = 17;     // Bytes per golden record
    localparam int max_cycles   = num_frames * 15 * 10 * clks_per_bit * 2 + 1000;

    logic       clk;
    logic       rst;
    logic       uart_rx;
    logic       uart_tx;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    resp_t      bresp;
    logic       bvalid;
    logic       bready;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    resp_t      rresp;
    logic       rvalid;
    logic       rready;

    byte_t gold [0:num_frames*rec_len-1];
    word_t mem [0:15];                    // Slave memory indexed by address bits 5:2
    byte_t rx_q [$];                      // Bytes seen on uart_tx
    int    cycles;
    int    stop_errors;
    int    strb_errors;

    uart_axil_bridge #(.clks_per_bit(clks_per_bit)) UUT (
        .clk(clk), .rst(rst), .uart_rx(uart_rx), .uart_tx(uart_tx),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    bind axil_master uart_axil_bridge_properties u_props (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wvalid(wvalid), .wready(wready), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .res_is_read(res_is_read)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles while waiting for responses", cycles);
        $display("TB FAILED");
        $finish;
    end

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_byte(input byte_t b);
        uart_rx = 1'b0;
        repeat (clks_per_bit) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            uart_rx = b[i];
            repeat (clks_per_bit) @(negedge clk);
        end
        uart_rx = 1'b1;
        repeat (clks_per_bit) @(negedge clk);
    endtask

    task automatic send_frame(input int rec);
        int base;
        base = rec * rec_len;
        for (int k = 0; k < int'(gold[base + 1]); k++) send_byte(gold[base + 2 + k]);
    endtask

    initial begin : tx_monitor
        byte_t b;
        stop_errors = 0;
        wait (rst === 1'b0);
        forever begin
            @(negedge uart_tx);
            repeat (clks_per_bit / 2) @(negedge clk);     // Middle of start bit
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge clk);
                b[i] = uart_tx;
            end
            repeat (clks_per_bit) @(negedge clk);
            assert (uart_tx === 1'b1) else begin
                $display("Stop bit on uart_tx was low at time %0t", $time);
                stop_errors++;
            end
            rx_q.push_back(b);
        end
    end

    // AXI4-Lite slave with random ready delays
    initial begin : axi_slave
        addr_t a;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        bresp       = 2'b00;
        arready     = 1'b0;
        rvalid      = 1'b0;
        rdata       = '0;
        rresp       = 2'b00;
        strb_errors = 0;
        void'($urandom(32'hb142_a20e));
        for (int i = 0; i < 16; i++) mem[i] = 32'hc0de_0000 + 32'(i) * 32'h0101;
        forever begin
            @(negedge clk);
            if (awvalid && wvalid) begin
                repeat ($urandom % 4) @(negedge clk);
                awready = 1'b1;
                a = awaddr;
                @(negedge clk);
                awready = 1'b0;
                repeat ($urandom % 4) @(negedge clk);
                wready = 1'b1;
                assert (wstrb === 4'hf) else begin
                    $display("error at time %0t: wstrb is %h, expected f", $time, wstrb);
                    strb_errors++;
                end
                if (!a[31]) mem[a[5:2]] = wdata;  // Error region ignores writes
                @(negedge clk);
                wready = 1'b0;
                repeat ($urandom % 4) @(negedge clk);
                bresp  = a[31] ? 2'b10 : 2'b00;
                bvalid = 1'b1;
                while (!bready) @(negedge clk);
                @(negedge clk);
                bvalid = 1'b0;
            end else if (arvalid) begin
                repeat ($urandom % 4) @(negedge clk);
                arready = 1'b1;
                a = araddr;
                @(negedge clk);
                arready = 1'b0;
                repeat ($urandom % 4) @(negedge clk);
                rresp  = a[31] ? 2'b10 : 2'b00;
                rdata  = a[31] ? '0 : mem[a[5:2]];
                rvalid = 1'b1;
                while (!rready) @(negedge clk);
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

    initial begin : main
        int    rec;
        int    base;
        int    test_id;
        int    tests_run;
        int    tests_failed;
        bit    ok;
        byte_t exp_q [$];

        rst          = 1'b1;
        uart_rx      = 1'b1;
        tests_run    = 0;
        tests_failed = 0;
        $readmemh("uart_axil_golden.txt", gold);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        rec = 0;
        while (rec < num_frames) begin
            test_id = int'(gold[rec * rec_len]);
            exp_q.delete();
            // Frames of one test go out back to back
            while (rec < num_frames && int'(gold[rec * rec_len]) == test_id) begin
                base = rec * rec_len;
                send_frame(rec);
                for (int k = 0; k < int'(gold[base + 11]); k++) begin
                    exp_q.push_back(gold[base + 12 + k]);
                end
                rec++;
            end
            while (rx_q.size() < exp_q.size()) @(negedge clk);
            repeat (2 * 10 * clks_per_bit) @(negedge clk);  // Catch extra bytes

            ok = 1'b1;
            assert (rx_q.size() == exp_q.size()) else begin
                $display("error at time %0t: test %0d returned %0d bytes, expected %0d",
                         $time, test_id, rx_q.size(), exp_q.size());
                ok = 1'b0;
            end
            for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
                assert (rx_q[i] === exp_q[i]) else begin
                    $display("error at time %0t: test %0d byte %0d is %02h, expected %02h",
                             $time, test_id, i, rx_q[i], exp_q[i]);
                    ok = 1'b0;
                end
            end
            tests_run++;
            if (!ok) tests_failed++;
            $display("test %0d %s with %0d response bytes", test_id,
                     ok ? "passed" : "failed", exp_q.size());
            rx_q.delete();
        end

        $display("tests %0d, failed %0d, stop bit errors %0d, strobe errors %0d, bus errors %0d",
                 tests_run, tests_failed, stop_errors, strb_errors,
                 UUT.u_master.u_props.fail_count);
        if (tests_failed == 0 && stop_errors == 0 && strb_errors == 0
            && UUT.u_master.u_props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- uart_axil_golden.txt
// test frame_len frame_bytes[9] resp_len resp_bytes[5], all hex
// unused frame and response bytes are zero
01 09 01 00 00 00 10 12 34 56 78 01 00 00 00 00 00
01 05 81 00 00 00 10 00 00 00 00 05 00 12 34 56 78
02 05 81 80 00 00 10 00 00 00 00 01 02 00 00 00 00
02 09 01 80 00 00 10 DE AD BE EF 01 02 00 00 00 00
02 05 81 00 00 00 10 00 00 00 00 05 00 12 34 56 78
03 01 55 00 00 00 00 00 00 00 00 01 07 00 00 00 00
03 05 81 00 00 00 10 00 00 00 00 05 00 12 34 56 78
04 09 01 00 00 00 20 A1 B2 C3 D4 01 00 00 00 00 00
04 05 81 00 00 00 20 00 00 00 00 05 00 A1 B2 C3 D4
04 09 01 80 00 00 04 00 00 00 00 01 02 00 00 00 00
04 05 81 80 00 00 00 00 00 00 00 01 02 00 00 00 00
04 05 81 00 00 00 10 00 00 00 00 05 00 12 34 56 78
05 09 01 00 00 00 24 0B AD F0 0D 01 00 00 00 00 00
05 09 01 00 00 00 28 CA FE BA BE 01 00 00 00 00 00
05 05 81 00 00 00 24 00 00 00 00 05 00 0B AD F0 0D
05 05 81 00 00 00 28 00 00 00 00 05 00 CA FE BA BE

//--- compile.f
bridge_pkg.sv
uart_rx.sv
frame_parser.sv
axil_master.sv
response_builder.sv
uart_tx.sv
uart_axil_bridge.sv
uart_axil_bridge_properties.sv
tb_uart_axil_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
    --top-module tb_uart_axil_bridge -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TB PASSED" sim.log && exit 0 || exit 1
